// File: clause_buffer.sv
// circular FIFO with registered read data and empty/full flags
`timescale 1ns/10ps

module clause_buffer #(
    parameter int DATA_WIDTH = 36,
    parameter int ADDR_WIDTH = 5
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [DATA_WIDTH-1:0] data_i,
    input  logic                  wr_en_i,
    input  logic                  rd_en_i,
    output logic [DATA_WIDTH-1:0] data_o,
    output logic                  empty_o,
    output logic                  full_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    // one extra bit so a full buffer is distinct from an empty one
    logic [ADDR_WIDTH:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    // writes into a full buffer and reads from an empty one are dropped
    assign do_wr = wr_en_i & ~full_o;
    assign do_rd = rd_en_i & ~empty_o;

    assign empty_o = (count == '0);
    // count reaches DEPTH only when the top bit is set
    assign full_o  = count[ADDR_WIDTH];

    // storage and read port
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_i;
        end
        // data_o holds its last word when nothing is read
        if (do_rd) begin
            data_o <= mem[rd_ptr];
        end
    end

    // pointers wrap naturally at DEPTH
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves occupancy unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: clause_fifo_tree.sv
// clause collection tree top: controller, leaf lanes and three merge stages
`timescale 1ns/10ps
`include "fifo_tree_consts.svh"

module clause_fifo_tree (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  clause_pkg::clause_vec_t     clauses_i,
    input  logic [`CT_CLAUSE_COUNT-1:0] clause_valid_i,
    input  logic                        wr_en_i,
    input  logic                        rd_en_i,
    input  logic                        clear_ovf_i,
    output clause_pkg::clause_t         clause_o,
    output logic                        empty_o,
    output logic                        overflow_o
);

    // load sequencing
    logic                      load_active;
    tree_ctrl_pkg::slot_idx_t  load_slot;

    // level 0 to level 1
    clause_pkg::lane_data_t    lane_data;
    logic [`CT_LANE_COUNT-1:0] lane_empty;
    logic [`CT_LANE_COUNT-1:0] lane_rd;
    logic                      leaf_ovf;

    // level 1 to level 2
    clause_pkg::clause_t [1:0] l1_data;
    logic [1:0]                l1_empty;
    logic [1:0]                l1_rd;
    logic [1:0]                l1_ovf;
    logic                      l2_ovf;

    tree_controller u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_en_i      (wr_en_i),
        .clear_ovf_i  (clear_ovf_i),
        .ovf_pulse_i  ({l2_ovf, l1_ovf, leaf_ovf}),
        .load_active_o(load_active),
        .load_slot_o  (load_slot),
        .overflow_o   (overflow_o)
    );

    leaf_stage u_leaf (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .clauses_i     (clauses_i),
        .clause_valid_i(clause_valid_i),
        .load_active_i (load_active),
        .load_slot_i   (load_slot),
        .lane_rd_i     (lane_rd),
        .lane_data_o   (lane_data),
        .lane_empty_o  (lane_empty),
        .ovf_o         (leaf_ovf)
    );

    // lanes 0 and 1
    merge_stage l1_merge_0 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .up_data_i (lane_data[1:0]),
        .up_empty_i(lane_empty[1:0]),
        .up_rd_o   (lane_rd[1:0]),
        .rd_en_i   (l1_rd[0]),
        .data_o    (l1_data[0]),
        .empty_o   (l1_empty[0]),
        .ovf_o     (l1_ovf[0])
    );

    // lanes 2 and 3
    merge_stage l1_merge_1 (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .up_data_i (lane_data[3:2]),
        .up_empty_i(lane_empty[3:2]),
        .up_rd_o   (lane_rd[3:2]),
        .rd_en_i   (l1_rd[1]),
        .data_o    (l1_data[1]),
        .empty_o   (l1_empty[1]),
        .ovf_o     (l1_ovf[1])
    );

    // output buffer, read directly by the solver
    merge_stage l2_merge (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .up_data_i (l1_data),
        .up_empty_i(l1_empty),
        .up_rd_o   (l1_rd),
        .rd_en_i   (rd_en_i),
        .data_o    (clause_o),
        .empty_o   (empty_o),
        .ovf_o     (l2_ovf)
    );

endmodule

// File: clause_fifo_tree_assert.sv
// bound checks on the clause tree top: reset flags, sticky overflow, one-hot merge reads
`timescale 1ns/10ps

module clause_fifo_tree_assert (
    input logic       clk_i,
    input logic       rst_i,
    input logic       empty_i,
    input logic       overflow_i,
    input logic       clear_ovf_i,
    input logic [3:0] lane_rd_i,
    input logic [1:0] l1_rd_i
);

    // first cycle out of reset sees an empty tree with no overflow
    a_reset_flags: assert property (@(posedge clk_i)
        $fell(rst_i) |-> (empty_i && !overflow_i))
        else $error("flags wrong right after reset");

    // sticky flag drops only through a clear or a reset
    a_ovf_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(overflow_i) |-> ($past(clear_ovf_i) || $past(rst_i)))
        else $error("overflow flag fell without a clear");

    // each merge reads one upstream side per cycle at most
    a_l1_0_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        !(lane_rd_i[0] && lane_rd_i[1]))
        else $error("l1_merge_0 read both lanes at once");

    a_l1_1_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        !(lane_rd_i[2] && lane_rd_i[3]))
        else $error("l1_merge_1 read both lanes at once");

    a_l2_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        !(l1_rd_i[0] && l1_rd_i[1]))
        else $error("l2_merge read both level-1 buffers at once");

endmodule

bind clause_fifo_tree clause_fifo_tree_assert u_tree_assert (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .empty_i    (empty_o),
    .overflow_i (overflow_o),
    .clear_ovf_i(clear_ovf_i),
    .lane_rd_i  (lane_rd),
    .l1_rd_i    (l1_rd)
);

// File: clause_fifo_tree_tb.sv
// clause tree testbench with random loads, per-lane scoreboard, drains and overflow checks
`timescale 1ns/10ps
`include "fifo_tree_consts.svh"

module clause_fifo_tree_tb;

    logic                        clk_i;
    logic                        rst_i;
    clause_pkg::clause_vec_t     clauses_i;
    logic [`CT_CLAUSE_COUNT-1:0] clause_valid_i;
    logic                        wr_en_i;
    logic                        rd_en_i;
    logic                        clear_ovf_i;
    clause_pkg::clause_t         clause_o;
    logic                        empty_o;
    logic                        overflow_o;

    // expected clauses per lane, in load order
    clause_pkg::clause_t lane_q [`CT_LANE_COUNT][$];
    logic [9:0]          seq_num [`CT_LANE_COUNT];
    integer              seed;
    int                  errors;
    int                  checks;
    int                  timeouts;
    int                  out_count;
    int                  last_valid;
    int                  peak_held;
    bit                  rd_pending;
    bit                  false_ovf_seen;

    clause_fifo_tree DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .clauses_i     (clauses_i),
        .clause_valid_i(clause_valid_i),
        .wr_en_i       (wr_en_i),
        .rd_en_i       (rd_en_i),
        .clear_ovf_i   (clear_ovf_i),
        .clause_o      (clause_o),
        .empty_o       (empty_o),
        .overflow_o    (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // clauses still owed by the DUT
    function automatic int held_count();
        int total;
        total = 0;
        for (int k = 0; k < `CT_LANE_COUNT; k++) begin
            total += lane_q[k].size();
        end
        return total;
    endfunction

    // lane id sits in the top two bits of every clause
    task automatic check_output();
        logic [1:0]          lane;
        clause_pkg::clause_t exp;
        lane = clause_o[`CT_CLAUSE_WIDTH-1 -: 2];
        out_count++;
        checks++;
        if (lane_q[lane].size() == 0) begin
            errors++;
            $display("t=%0t: clause %h from lane %0d was never expected", $time,
                     clause_o, lane);
        end else begin
            exp = lane_q[lane].pop_front();
            if (clause_o !== exp) begin
                errors++;
                $display("FAIL t=%0t clause_o: got %h, expected %h", $time, clause_o, exp);
            end
        end
    endtask

    // check the last read, then pick a new read with odds of read_eighths in 8
    task automatic tick(input int read_eighths);
        int roll;
        @(negedge clk_i);
        if (rd_pending) begin
            check_output();
        end
        roll = $random(seed) & 7;
        rd_en_i = (roll < read_eighths) && !empty_o;
        rd_pending = rd_en_i;
        // no buffer can fill while the whole tree holds at most one buffer's worth
        if (overflow_o && peak_held <= `CT_BUFFER_DEPTH && !false_ovf_seen) begin
            false_ovf_seen = 1'b1;
            errors++;
            $display("FAIL t=%0t overflow_o: got %b, expected 0, at most %0d held", $time,
                     overflow_o, peak_held);
        end
    endtask

    // strobe one random vector and hold it for the five slot cycles
    task automatic load_random(input bit all_valid, input int read_eighths);
        clause_pkg::clause_vec_t     vec;
        logic [`CT_CLAUSE_COUNT-1:0] mask;
        int                          n;
        mask = all_valid ? '1 : `CT_CLAUSE_COUNT'($random(seed));
        for (int k = 0; k < `CT_LANE_COUNT; k++) begin
            for (int j = 0; j < `CT_GROUP_SIZE; j++) begin
                n = k * `CT_GROUP_SIZE + j;
                // lane, sequence number, filler
                vec[n] = {2'(k), seq_num[k], 24'($random(seed))};
                seq_num[k]++;
                if (mask[n]) begin
                    lane_q[k].push_back(vec[n]);
                end
            end
        end
        last_valid = $countones(mask);
        if (held_count() > peak_held) begin
            peak_held = held_count();
        end
        tick(read_eighths);
        clauses_i = vec;
        clause_valid_i = mask;
        wr_en_i = 1'b1;
        repeat (`CT_GROUP_SIZE - 1) begin
            tick(read_eighths);
            wr_en_i = 1'b0;
        end
    endtask

    // read until every expected clause is out, then look for strays
    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while (held_count() > 0 && waited < limit) begin
            tick(8);
            waited++;
        end
        if (held_count() > 0) begin
            errors++;
            timeouts++;
            $display("t=%0t: drain timed out, %0d clauses never came out", $time, held_count());
        end
        repeat (16) tick(8);
        tick(0);
        checks++;
        if (empty_o !== 1'b1) begin
            errors++;
            $display("FAIL t=%0t empty_o: got %b, expected 1", $time, empty_o);
        end
    endtask

    initial begin
        int waited;
        seed = 32'hd408_fce8;
        errors = 0;
        checks = 0;
        timeouts = 0;
        out_count = 0;
        peak_held = 0;
        rd_pending = 1'b0;
        false_ovf_seen = 1'b0;
        for (int k = 0; k < `CT_LANE_COUNT; k++) begin
            seq_num[k] = '0;
        end
        rst_i = 1'b1;
        clauses_i = '0;
        clause_valid_i = '0;
        wr_en_i = 1'b0;
        rd_en_i = 1'b0;
        clear_ovf_i = 1'b0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // reset state
        tick(0);
        checks++;
        if (empty_o !== 1'b1 || overflow_o !== 1'b0) begin
            errors++;
            $display("FAIL t=%0t empty_o/overflow_o: got %b/%b, expected 1/0", $time,
                     empty_o, overflow_o);
        end

        // single load then full drain
        out_count = 0;
        load_random(1'b0, 0);
        drain(400);
        checks++;
        if (out_count != last_valid) begin
            errors++;
            $display("FAIL t=%0t out_count: got %0d, expected %0d", $time, out_count, last_valid);
        end

        // several loads with reads running alongside
        repeat (3) begin
            repeat (4) begin
                load_random(1'b0, 7);
                repeat (4 + ($random(seed) & 7)) tick(7);
            end
            drain(600);
        end

        // 12 full loads without reading put 240 clauses into the tree
        repeat (12) load_random(1'b1, 0);
        waited = 0;
        while (!overflow_o && waited < 400) begin
            tick(0);
            waited++;
        end
        if (!overflow_o) begin
            errors++;
            timeouts++;
            $display("t=%0t: overflow_o never rose after overfilling the tree", $time);
        end
        // long enough for the merges to stop dropping words
        repeat (300) begin
            tick(0);
            checks++;
            if (overflow_o !== 1'b1) begin
                errors++;
                $display("FAIL t=%0t overflow_o: got %b, expected 1", $time, overflow_o);
            end
        end
        tick(0);
        clear_ovf_i = 1'b1;
        tick(0);
        clear_ovf_i = 1'b0;
        repeat (20) begin
            tick(0);
            checks++;
            if (overflow_o !== 1'b0) begin
                errors++;
                $display("FAIL t=%0t overflow_o: got %b, expected 0", $time, overflow_o);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: clause_pkg.sv
// clause word, load vector and per-lane data types
`include "fifo_tree_consts.svh"

package clause_pkg;

    // one clause as seen by the solver
    typedef logic [`CT_CLAUSE_WIDTH-1:0] clause_t;

    // whole load vector, slot n at word n
    typedef clause_t [`CT_CLAUSE_COUNT-1:0] clause_vec_t;

    // one word per leaf lane
    typedef clause_t [`CT_LANE_COUNT-1:0] lane_data_t;

endpackage

// File: fifo_tree_consts.svh
// clause tree sizing macros: clause width and count, lanes, group size, buffer depth
`ifndef FIFO_TREE_CONSTS_SVH
`define FIFO_TREE_CONSTS_SVH

// bits per clause word
`define CT_CLAUSE_WIDTH 36

// clause slots in one load vector
`define CT_CLAUSE_COUNT 20

// leaf lanes at level 0
`define CT_LANE_COUNT 4

// slots owned by each lane, lane k has 5k to 5k+4
`define CT_GROUP_SIZE 5

// entries in every buffer of the tree
`define CT_BUFFER_DEPTH 32
`define CT_ADDR_WIDTH $clog2(`CT_BUFFER_DEPTH)

`endif

// File: leaf_stage.sv
// level-0 lanes: slot select from the load vector into four buffers
`timescale 1ns/10ps
`include "fifo_tree_consts.svh"

module leaf_stage (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  clause_pkg::clause_vec_t      clauses_i,
    input  logic [`CT_CLAUSE_COUNT-1:0]  clause_valid_i,
    input  logic                         load_active_i,
    input  tree_ctrl_pkg::slot_idx_t     load_slot_i,
    input  logic [`CT_LANE_COUNT-1:0]    lane_rd_i,
    output clause_pkg::lane_data_t       lane_data_o,
    output logic [`CT_LANE_COUNT-1:0]    lane_empty_o,
    output logic                         ovf_o
);

    localparam int SLOT_W = $clog2(`CT_CLAUSE_COUNT);

    logic [`CT_LANE_COUNT-1:0] lane_wr;
    logic [`CT_LANE_COUNT-1:0] lane_full;

    // any lane hitting a full buffer
    assign ovf_o = |(lane_wr & lane_full);

    for (genvar k = 0; k < `CT_LANE_COUNT; k++) begin : g_lane
        logic [SLOT_W-1:0]   slot_n;
        clause_pkg::clause_t lane_din;

        // lane k owns slots 5k to 5k+4
        assign slot_n   = SLOT_W'(k * `CT_GROUP_SIZE) + SLOT_W'(load_slot_i);
        assign lane_din = clauses_i[slot_n];
        // invalid slots are skipped, not written as holes
        assign lane_wr[k] = load_active_i & clause_valid_i[slot_n];

        clause_buffer #(
            .DATA_WIDTH(`CT_CLAUSE_WIDTH),
            .ADDR_WIDTH(`CT_ADDR_WIDTH)
        ) u_lane_buf (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .data_i (lane_din),
            .wr_en_i(lane_wr[k]),
            .rd_en_i(lane_rd_i[k]),
            .data_o (lane_data_o[k]),
            .empty_o(lane_empty_o[k]),
            .full_o (lane_full[k])
        );
    end

endmodule

// File: merge_stage.sv
// two-into-one merge with alternating preference and a downstream buffer
`timescale 1ns/10ps
`include "fifo_tree_consts.svh"

module merge_stage (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  clause_pkg::clause_t [1:0] up_data_i,
    input  logic [1:0]                up_empty_i,
    output logic [1:0]                up_rd_o,
    input  logic                      rd_en_i,
    output clause_pkg::clause_t       data_o,
    output logic                      empty_o,
    output logic                      ovf_o
);

    // input currently favored
    logic                pref_q;
    // which input was read last cycle
    logic                src_q;
    // upstream read last cycle, data arrives now
    logic                wr_q;
    logic                full;
    clause_pkg::clause_t merge_din;

    // preferred input if it has data, else the other one
    // never both in the same cycle
    assign up_rd_o[0] = ~up_empty_i[0] & (~pref_q | up_empty_i[1]);
    assign up_rd_o[1] = ~up_empty_i[1] & (pref_q | up_empty_i[0]);

    // upstream data_o is registered, so pick by the delayed source
    assign merge_din = up_data_i[src_q];

    assign ovf_o = wr_q & full;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pref_q <= 1'b0;
            src_q  <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            // flip only when the favored side actually had data
            pref_q <= pref_q ^ ~up_empty_i[pref_q];
            src_q  <= up_rd_o[1];
            wr_q   <= |up_rd_o;
        end
    end

    clause_buffer #(
        .DATA_WIDTH(`CT_CLAUSE_WIDTH),
        .ADDR_WIDTH(`CT_ADDR_WIDTH)
    ) u_merge_buf (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .data_i (merge_din),
        .wr_en_i(wr_q),
        .rd_en_i(rd_en_i),
        .data_o (data_o),
        .empty_o(empty_o),
        .full_o (full)
    );

endmodule

// File: tb.f
+incdir+.
clause_pkg.sv
tree_ctrl_pkg.sv
clause_buffer.sv
tree_controller.sv
leaf_stage.sv
merge_stage.sv
clause_fifo_tree.sv
clause_fifo_tree_assert.sv
clause_fifo_tree_tb.sv

// File: tree_controller.sv
// load sequencer FSM with slot counter and sticky overflow flag
`timescale 1ns/10ps
`include "fifo_tree_consts.svh"

module tree_controller (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     wr_en_i,
    input  logic                     clear_ovf_i,
    // bit 0 leaf, bits 1 and 2 level-1 merges, bit 3 level-2 merge
    input  logic [3:0]               ovf_pulse_i,
    output logic                     load_active_o,
    output tree_ctrl_pkg::slot_idx_t load_slot_o,
    output logic                     overflow_o
);

    localparam tree_ctrl_pkg::slot_idx_t LAST_SLOT =
        tree_ctrl_pkg::slot_idx_t'(`CT_GROUP_SIZE - 1);

    tree_ctrl_pkg::load_state_t state_q;
    // slot to present on the next RUN cycle
    tree_ctrl_pkg::slot_idx_t   slot_q;

    // slot 0 goes out in the strobe cycle itself
    assign load_active_o = wr_en_i | (state_q == tree_ctrl_pkg::LOAD_RUN);
    assign load_slot_o   = wr_en_i ? '0 : slot_q;

    // five-cycle load sequence
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= tree_ctrl_pkg::LOAD_IDLE;
            slot_q  <= '0;
        end else if (wr_en_i) begin
            // a strobe mid-load restarts from slot 0, so slot 1 is next
            state_q <= tree_ctrl_pkg::LOAD_RUN;
            slot_q  <= tree_ctrl_pkg::slot_idx_t'(1);
        end else begin
            case (state_q)
                tree_ctrl_pkg::LOAD_RUN: begin
                    if (slot_q == LAST_SLOT) begin
                        state_q <= tree_ctrl_pkg::LOAD_IDLE;
                        slot_q  <= '0;
                    end else begin
                        slot_q <= slot_q + 1'b1;
                    end
                end
                default: begin
                    slot_q <= '0;
                end
            endcase
        end
    end

    // sticky overflow, clear beats a pulse in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i || clear_ovf_i) begin
            overflow_o <= 1'b0;
        end else begin
            overflow_o <= overflow_o | (|ovf_pulse_i);
        end
    end

endmodule

// File: tree_ctrl_pkg.sv
// load sequencer state encoding and slot index type
`include "fifo_tree_consts.svh"

package tree_ctrl_pkg;

    // idle, or stepping through the five slots of a load
    typedef enum logic {
        LOAD_IDLE = 1'b0,
        LOAD_RUN  = 1'b1
    } load_state_t;

    // slot within a lane group, 0 to 4
    typedef logic [$clog2(`CT_GROUP_SIZE)-1:0] slot_idx_t;

endpackage
